//--- bomber_settings.svh
`ifndef BOMBER_SETTINGS_SVH
`define BOMBER_SETTINGS_SVH

// ------------------------------
// Map geometry
// ------------------------------

// Maze size in tiles
`define BOMBER_NUM_ROW 11
`define BOMBER_NUM_COL 19

// ------------------------------
// Bomb timing, in frame ticks
// ------------------------------

// Ticks from placement until the bomb goes off
`define BOMBER_FUSE_TICKS 3
// Ticks the blast stays on screen
`define BOMBER_EXPLODE_TICKS 4
// Width of every tick counter
`define BOMBER_TICK_CNT_W 6

`endif

//--- bomber_pkg.sv
`include "bomber_settings.svh"

package bomber_pkg;

  // Map size and address widths
  localparam int DEPTH  = `BOMBER_NUM_ROW * `BOMBER_NUM_COL;
  localparam int ADDR_W = $clog2(DEPTH);
  localparam int ROW_W  = $clog2(`BOMBER_NUM_ROW);
  localparam int COL_W  = $clog2(`BOMBER_NUM_COL);

  // Linear tile index, row * NUM_COL + col
  typedef logic [ADDR_W-1:0] tile_addr_t;

  typedef enum logic [1:0] {
    TILE_EMPTY = 2'd0,
    TILE_SOFT  = 2'd1,
    TILE_WALL  = 2'd2
  } tile_t;

  typedef enum logic [1:0] {
    EXP_STATE_IDLE        = 2'd0,
    EXP_STATE_ACTIVE      = 2'd1,
    EXP_STATE_FREE_BLOCKS = 2'd2
  } bomb_explosion_state_t;

  // One-cycle request carrying a tile address
  typedef struct packed {
    logic       valid;
    tile_addr_t addr;
  } blast_req_t;

  // Single tile write into the map
  typedef struct packed {
    logic       valid;
    tile_addr_t addr;
    tile_t      tile;
  } tile_wr_t;

  // Split a linear address into row and column
  function automatic logic [ROW_W-1:0] tile_row(tile_addr_t addr);
    return ROW_W'(addr / `BOMBER_NUM_COL);
  endfunction

  function automatic logic [COL_W-1:0] tile_col(tile_addr_t addr);
    return COL_W'(addr % `BOMBER_NUM_COL);
  endfunction

  // Start-of-round maze: pillars on odd/odd, free corner at 0, soft blocks elsewhere
  function automatic tile_t init_tile(tile_addr_t addr);
    logic [ROW_W-1:0] r;
    logic [COL_W-1:0] c;
    r = tile_row(addr);
    c = tile_col(addr);
    if (addr == '0) return TILE_EMPTY;
    if (r[0] && c[0]) return TILE_WALL;
    return TILE_SOFT;
  endfunction

endpackage

//--- bomb_fuse.sv
`include "bomber_settings.svh"

module bomb_fuse (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   tick,
  input  logic                   game_over,
  input  logic                   place,
  input  bomber_pkg::tile_addr_t place_addr,
  input  logic                   blast_busy,
  input  logic                   clear_busy,
  output logic                   bomb_armed,
  output bomber_pkg::blast_req_t fuse_req
);
  import bomber_pkg::*;

  localparam int CNT_W = `BOMBER_TICK_CNT_W;
  // Counter value on the tick that burns out the fuse
  localparam logic [CNT_W-1:0] LAST_TICK = CNT_W'(`BOMBER_FUSE_TICKS - 1);

  logic [CNT_W-1:0] tick_cnt;
  tile_addr_t       bomb_addr;
  logic             fire_q;
  logic             accept;
  logic             fuse_done;

  // Only one bomb in flight, also blocked while the request is on the wire
  assign accept    = place && !bomb_armed && !fuse_req.valid && !blast_busy && !clear_busy;
  assign fuse_done = bomb_armed && tick && (tick_cnt == LAST_TICK);

  // ------------------------------
  // Armed flag and fuse counter
  // ------------------------------
  always_ff @(posedge clk) begin
    if (rst || game_over) begin
      bomb_armed <= 1'b0;
      tick_cnt   <= '0;
      fire_q     <= 1'b0;
    end else begin
      // Request goes out the cycle after the last tick
      fire_q <= fuse_done;
      if (accept) begin
        bomb_armed <= 1'b1;
        tick_cnt   <= '0;
      end else if (fuse_done) begin
        bomb_armed <= 1'b0;
        tick_cnt   <= '0;
      end else if (bomb_armed && tick) begin
        tick_cnt <= tick_cnt + 1'b1;
      end
    end
  end

  // Placed tile
  always_ff @(posedge clk) begin
    if (accept) begin
      bomb_addr <= place_addr;
    end
  end

  assign fuse_req.valid = fire_q;
  assign fuse_req.addr  = bomb_addr;

  // Explosion controller must be idle when the fuse fires
  a_fuse_not_busy: assert property (@(posedge clk) disable iff (rst)
    fuse_req.valid |-> !blast_busy)
    else $error("fuse request while blast still busy");

endmodule

//--- explode_logic.sv
`include "bomber_settings.svh"

module explode_logic (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   tick,
  input  logic                   game_over,
  input  bomber_pkg::blast_req_t fuse_req,
  output logic                   explode_active,
  output logic                   blast_busy,
  output bomber_pkg::tile_addr_t blast_addr,
  output bomber_pkg::blast_req_t free_req
);
  import bomber_pkg::*;

  localparam int CNT_W = `BOMBER_TICK_CNT_W;
  localparam logic [CNT_W-1:0] LAST_TICK = CNT_W'(`BOMBER_EXPLODE_TICKS - 1);

  bomb_explosion_state_t st;
  bomb_explosion_state_t nst;
  logic [CNT_W-1:0]      tick_cnt;
  tile_addr_t            saved_addr;
  logic                  blast_done;

  // Last blast tick counted this cycle
  assign blast_done = tick && (tick_cnt == LAST_TICK);

  // ------------------------------
  // Explosion FSM
  // ------------------------------
  always_ff @(posedge clk) begin
    if (rst || game_over) begin
      st <= EXP_STATE_IDLE;
    end else begin
      st <= nst;
    end
  end

  always_comb begin
    nst = st;
    case (st)
      EXP_STATE_IDLE:        if (fuse_req.valid) nst = EXP_STATE_ACTIVE;
      EXP_STATE_ACTIVE:      if (blast_done) nst = EXP_STATE_FREE_BLOCKS;
      // Single cycle, then back to idle
      EXP_STATE_FREE_BLOCKS: nst = EXP_STATE_IDLE;
      default:               nst = EXP_STATE_IDLE;
    endcase
  end

  // ------------------------------
  // Blast timer and saved address
  // ------------------------------
  always_ff @(posedge clk) begin
    if (rst || game_over) begin
      tick_cnt <= '0;
    end else if (st == EXP_STATE_ACTIVE) begin
      if (tick) tick_cnt <= tick_cnt + 1'b1;
    end else begin
      tick_cnt <= '0;
    end
  end

  always_ff @(posedge clk) begin
    if (st == EXP_STATE_IDLE && fuse_req.valid) begin
      saved_addr <= fuse_req.addr;
    end
  end

  assign explode_active = (st == EXP_STATE_ACTIVE);
  assign blast_busy     = (st != EXP_STATE_IDLE);
  assign blast_addr     = saved_addr;
  assign free_req.valid = (st == EXP_STATE_FREE_BLOCKS);
  assign free_req.addr  = saved_addr;

  // Last tick gives exactly one free-blocks pulse
  a_free_one_cycle: assert property (@(posedge clk) disable iff (rst)
    (explode_active && blast_done && !game_over) |=> free_req.valid ##1 !free_req.valid)
    else $error("free-blocks pulse is not one cycle");

endmodule

//--- blast_clear.sv
`include "bomber_settings.svh"

module blast_clear (
  input  logic                   clk,
  input  logic                   rst,
  input  bomber_pkg::blast_req_t free_req,
  output bomber_pkg::tile_addr_t peek_addr,
  input  bomber_pkg::tile_t      peek_tile,
  output bomber_pkg::tile_wr_t   map_wr,
  output logic                   clear_busy
);
  import bomber_pkg::*;

  localparam int NUM_ROW = `BOMBER_NUM_ROW;
  localparam int NUM_COL = `BOMBER_NUM_COL;

  // Cross walk order
  localparam logic [2:0] STEP_CENTRE = 3'd0;
  localparam logic [2:0] STEP_UP     = 3'd1;
  localparam logic [2:0] STEP_DOWN   = 3'd2;
  localparam logic [2:0] STEP_LEFT   = 3'd3;
  localparam logic [2:0] STEP_RIGHT  = 3'd4;

  tile_addr_t       centre;
  logic [ROW_W-1:0] centre_row;
  logic [COL_W-1:0] centre_col;
  logic [2:0]       step;
  tile_addr_t       nb_addr;
  logic             in_range;
  logic             start;

  assign start = free_req.valid && !clear_busy;

  // ------------------------------
  // Step sequencer for five busy cycles
  // ------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      clear_busy <= 1'b0;
      step       <= STEP_CENTRE;
    end else if (start) begin
      clear_busy <= 1'b1;
      step       <= STEP_CENTRE;
    end else if (clear_busy) begin
      if (step == STEP_RIGHT) clear_busy <= 1'b0;
      step <= step + 1'b1;
    end
  end

  // Centre tile split once so bounds checks are simple compares
  always_ff @(posedge clk) begin
    if (start) begin
      centre     <= free_req.addr;
      centre_row <= tile_row(free_req.addr);
      centre_col <= tile_col(free_req.addr);
    end
  end

  // Neighbour address and edge check without wrap to the next row
  always_comb begin
    nb_addr  = centre;
    in_range = 1'b1;
    case (step)
      STEP_CENTRE: nb_addr = centre;
      STEP_UP: begin
        in_range = (centre_row != '0);
        nb_addr  = centre - tile_addr_t'(NUM_COL);
      end
      STEP_DOWN: begin
        in_range = (centre_row != ROW_W'(NUM_ROW - 1));
        nb_addr  = centre + tile_addr_t'(NUM_COL);
      end
      STEP_LEFT: begin
        in_range = (centre_col != '0);
        nb_addr  = centre - 1'b1;
      end
      STEP_RIGHT: begin
        in_range = (centre_col != COL_W'(NUM_COL - 1));
        nb_addr  = centre + 1'b1;
      end
      default: in_range = 1'b0;
    endcase
  end

  assign peek_addr = nb_addr;

  // Only soft blocks break
  assign map_wr.valid = clear_busy && in_range && (peek_tile == TILE_SOFT);
  assign map_wr.addr  = nb_addr;
  assign map_wr.tile  = TILE_EMPTY;

  // Every write lands on the centre's own row or column
  a_write_in_cross: assert property (@(posedge clk) disable iff (rst)
    map_wr.valid |-> (tile_row(map_wr.addr) == centre_row) ||
      (tile_col(map_wr.addr) == centre_col))
    else $error("write outside the blast cross");

  a_walk_length: assert property (@(posedge clk) disable iff (rst)
    start |=> clear_busy [*5] ##1 !clear_busy)
    else $error("cross walk is not five cycles");

endmodule

//--- tile_map.sv
`include "bomber_settings.svh"

module tile_map (
  input  logic                   clk,
  input  logic                   rst,
  input  bomber_pkg::tile_wr_t   map_wr,
  input  bomber_pkg::tile_addr_t peek_addr,
  output bomber_pkg::tile_t      peek_tile,
  input  bomber_pkg::tile_addr_t rd_addr,
  output bomber_pkg::tile_t      rd_tile
);
  import bomber_pkg::*;

  // One tile per map cell
  tile_t mem [DEPTH];

  logic wr_ok;
  logic peek_ok;
  logic rd_ok;

  // Addresses past the last tile are outside the maze
  assign wr_ok   = map_wr.valid && (map_wr.addr < DEPTH);
  assign peek_ok = (peek_addr < DEPTH);
  assign rd_ok   = (rd_addr < DEPTH);

  // ------------------------------
  // Array load and write port
  // ------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      // Fresh maze every reset
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= init_tile(tile_addr_t'(i));
      end
    end else if (wr_ok) begin
      mem[map_wr.addr] <= map_wr.tile;
    end
  end

  // ------------------------------
  // Read ports
  // ------------------------------

  // Peek is combinational, the clearing block decides in the same cycle
  assign peek_tile = peek_ok ? mem[peek_addr] : TILE_WALL;

  // Renderer port, one cycle latency
  always_ff @(posedge clk) begin
    if (rd_ok) begin
      rd_tile <= mem[rd_addr];
    end else begin
      rd_tile <= TILE_WALL;
    end
  end

endmodule

//--- bomber_blast_top.sv
module bomber_blast_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   tick,
  input  logic                   game_over,
  input  logic                   place,
  input  bomber_pkg::tile_addr_t place_addr,
  input  bomber_pkg::tile_addr_t rd_addr,
  output logic                   bomb_armed,
  output logic                   explode_active,
  output bomber_pkg::tile_addr_t blast_addr,
  output logic                   clear_busy,
  output bomber_pkg::tile_t      rd_tile
);
  import bomber_pkg::*;

  // Block-to-block pulses
  blast_req_t fuse_req;
  blast_req_t free_req;
  tile_wr_t   map_wr;
  // Busy feedback and map peek
  logic       blast_busy;
  tile_addr_t peek_addr;
  tile_t      peek_tile;

  // Placement and fuse
  bomb_fuse u_fuse (
    .clk        (clk),
    .rst        (rst),
    .tick       (tick),
    .game_over  (game_over),
    .place      (place),
    .place_addr (place_addr),
    .blast_busy (blast_busy),
    .clear_busy (clear_busy),
    .bomb_armed (bomb_armed),
    .fuse_req   (fuse_req)
  );

  // Blast timing
  explode_logic u_explode (
    .clk            (clk),
    .rst            (rst),
    .tick           (tick),
    .game_over      (game_over),
    .fuse_req       (fuse_req),
    .explode_active (explode_active),
    .blast_busy     (blast_busy),
    .blast_addr     (blast_addr),
    .free_req       (free_req)
  );

  // Cross walk
  blast_clear u_clear (
    .clk        (clk),
    .rst        (rst),
    .free_req   (free_req),
    .peek_addr  (peek_addr),
    .peek_tile  (peek_tile),
    .map_wr     (map_wr),
    .clear_busy (clear_busy)
  );

  tile_map u_map (
    .clk       (clk),
    .rst       (rst),
    .map_wr    (map_wr),
    .peek_addr (peek_addr),
    .peek_tile (peek_tile),
    .rd_addr   (rd_addr),
    .rd_tile   (rd_tile)
  );

endmodule

//--- tb_clock.sv
module tb_clock (
  output logic clk,
  output logic rst
);

  // Free-running clock, period 4
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Synchronous reset held for the first 16 rising edges
  initial begin
    rst = 1'b1;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

//--- bomber_tb.sv
`include "bomber_settings.svh"

module bomber_tb;
  import bomber_pkg::*;

  localparam int NUM_ROW = `BOMBER_NUM_ROW;
  localparam int NUM_COL = `BOMBER_NUM_COL;
  // Run length covers four map sweeps and up to six bomb rounds with a tick every 5 cycles
  localparam int SWEEP_CYC = DEPTH + 4;
  localparam int BOMB_CYC  = (`BOMBER_FUSE_TICKS + `BOMBER_EXPLODE_TICKS + 2) * 5 + 12;
  localparam int TIMEOUT   = 5 * (16 + 4 * SWEEP_CYC + 6 * BOMB_CYC);

  // Expected read-port result one cycle behind rd_addr
  typedef struct packed {
    logic  chk;
    tile_t tile;
  } rd_check_t;

  logic       clk;
  logic       rst;
  logic       tick;
  logic       game_over;
  logic       place;
  tile_addr_t place_addr;
  tile_addr_t rd_addr;
  logic       bomb_armed;
  logic       explode_active;
  tile_addr_t blast_addr;
  logic       clear_busy;
  tile_t      rd_tile;

  tile_t      model [DEPTH];
  rd_check_t  rd_exp;
  tile_addr_t exp_addr;
  int         armed_ticks;
  int         blast_ticks;
  int         tick_div;
  int         cycle_cnt;
  int         err_cnt;
  int         tests_run;
  integer     seed = 63;

  tb_clock u_clk (
    .clk (clk),
    .rst (rst)
  );

  bomber_blast_top u_dut (
    .clk            (clk),
    .rst            (rst),
    .tick           (tick),
    .game_over      (game_over),
    .place          (place),
    .place_addr     (place_addr),
    .rd_addr        (rd_addr),
    .bomb_armed     (bomb_armed),
    .explode_active (explode_active),
    .blast_addr     (blast_addr),
    .clear_busy     (clear_busy),
    .rd_tile        (rd_tile)
  );

  // ------------------------------
  // Frame tick, tick counters, watchdog
  // ------------------------------
  always @(posedge clk) begin
    if (rst) begin
      tick_div <= 0;
      tick     <= 1'b0;
    end else begin
      tick_div <= (tick_div == 4) ? 0 : tick_div + 1;
      tick     <= (tick_div == 4);
    end
  end

  // Ticks seen while armed and restarted by a placement that should be taken
  always @(posedge clk) begin
    if (rst || (place && !bomb_armed && !explode_active))
      armed_ticks <= 0;
    else if (tick && bomb_armed)
      armed_ticks <= armed_ticks + 1;
  end

  // Ticks seen during the blast
  always @(posedge clk) begin
    if (!explode_active)
      blast_ticks <= 0;
    else if (tick)
      blast_ticks <= blast_ticks + 1;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
      $display("Test FAILED");
      $finish;
    end
  end

  // ------------------------------
  // Checks
  // ------------------------------
  a_reset_idle: assert property (@(posedge clk)
    rst |=> !bomb_armed && !explode_active && !clear_busy)
    else begin
      err_cnt++;
      $display("FAILED %0t: outputs not idle after reset", $time);
    end

  // Registered read port against the model
  a_read_back: assert property (@(posedge clk) disable iff (rst)
    rd_exp.chk |=> rd_tile == $past(rd_exp.tile))
    else begin
      err_cnt++;
      $display("FAILED %0t: rd_tile %0d at addr %0d, expected %0d",
               $time, rd_tile, $past(rd_addr), $past(rd_exp.tile));
    end

  a_armed_on_place: assert property (@(posedge clk) disable iff (rst)
    (place && !bomb_armed && !explode_active && !clear_busy && !game_over) |=> bomb_armed)
    else begin
      err_cnt++;
      $display("FAILED %0t: bomb_armed did not rise after place", $time);
    end

  a_fuse_ticks: assert property (@(posedge clk) disable iff (rst)
    $rose(explode_active) |-> armed_ticks == `BOMBER_FUSE_TICKS)
    else begin
      err_cnt++;
      $display("FAILED %0t: blast after %0d fuse ticks", $time, armed_ticks);
    end

  a_blast_addr: assert property (@(posedge clk) disable iff (rst)
    explode_active |-> blast_addr == exp_addr)
    else begin
      err_cnt++;
      $display("FAILED %0t: blast_addr %0d, expected %0d", $time, blast_addr, exp_addr);
    end

  // Second bomb during the blast must be dropped
  a_refused_in_blast: assert property (@(posedge clk) disable iff (rst)
    (place && explode_active) |=> !bomb_armed)
    else begin
      err_cnt++;
      $display("FAILED %0t: place accepted during the blast", $time);
    end

  // The last blast tick is already in the count when explode_active falls
  a_blast_ticks: assert property (@(posedge clk) disable iff (rst)
    ($fell(explode_active) && !$past(game_over)) |-> blast_ticks ==
      `BOMBER_EXPLODE_TICKS)
    else begin
      err_cnt++;
      $display("FAILED %0t: blast lasted %0d ticks", $time, blast_ticks);
    end

  // Cross walk right after the free-blocks cycle
  a_clear_walk: assert property (@(posedge clk) disable iff (rst)
    ($fell(explode_active) && !$past(game_over)) |=> clear_busy [*5] ##1 !clear_busy)
    else begin
      err_cnt++;
      $display("FAILED %0t: clear_busy is not a five-cycle pulse", $time);
    end

  a_game_over: assert property (@(posedge clk) disable iff (rst)
    game_over |=> !bomb_armed && !explode_active)
    else begin
      err_cnt++;
      $display("FAILED %0t: bomb still live after game_over", $time);
    end

  // ------------------------------
  // Reference model of the map
  // ------------------------------

  // Start maze with a free corner, pillars where row and column are odd, soft elsewhere
  function automatic tile_t maze_start_tile(int a);
    int r;
    int c;
    r = a / NUM_COL;
    c = a % NUM_COL;
    if (a == 0)
      return TILE_EMPTY;
    else if ((r % 2 == 1) && (c % 2 == 1))
      return TILE_WALL;
    else
      return TILE_SOFT;
  endfunction

  task automatic break_soft(input int r, input int c);
    // Off-map neighbours are skipped
    if (r >= 0 && r < NUM_ROW && c >= 0 && c < NUM_COL) begin
      if (model[r * NUM_COL + c] == TILE_SOFT)
        model[r * NUM_COL + c] = TILE_EMPTY;
    end
  endtask

  task automatic apply_cross(input int centre);
    int r;
    int c;
    r = centre / NUM_COL;
    c = centre % NUM_COL;
    break_soft(r, c);
    break_soft(r - 1, c);
    break_soft(r + 1, c);
    break_soft(r, c - 1);
    break_soft(r, c + 1);
  endtask

  // Interior tile on an even column can never be a pillar
  function automatic tile_addr_t interior_addr();
    int r;
    int c;
    r = 1 + $unsigned($random(seed)) % (NUM_ROW - 2);
    c = 2 + 2 * ($unsigned($random(seed)) % 8);
    return tile_addr_t'(r * NUM_COL + c);
  endfunction

  // ------------------------------
  // Stimulus tasks
  // ------------------------------

  // Read every tile once in shuffled order
  task automatic sweep_map();
    int order [DEPTH];
    int j;
    int tmp;
    for (int i = 0; i < DEPTH; i++)
      order[i] = i;
    for (int i = DEPTH - 1; i > 0; i--) begin
      j        = $unsigned($random(seed)) % (i + 1);
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    for (int i = 0; i < DEPTH; i++) begin
      @(posedge clk);
      rd_addr     <= tile_addr_t'(order[i]);
      rd_exp.chk  <= 1'b1;
      rd_exp.tile <= model[order[i]];
    end
    @(posedge clk);
    rd_exp.chk <= 1'b0;
    repeat (2) @(posedge clk);
  endtask

  task automatic drop_bomb(input tile_addr_t a, input logic expect_taken);
    @(posedge clk);
    place      <= 1'b1;
    place_addr <= a;
    if (expect_taken)
      exp_addr <= a;
    @(posedge clk);
    place <= 1'b0;
  endtask

  task automatic pulse_game_over();
    @(posedge clk);
    game_over <= 1'b1;
    @(posedge clk);
    game_over <= 1'b0;
    repeat (3) @(posedge clk);
  endtask

  task automatic wait_blast_done();
    while (!explode_active) @(posedge clk);
    while (explode_active) @(posedge clk);
    while (!clear_busy) @(posedge clk);
    while (clear_busy) @(posedge clk);
  endtask

  task automatic report_test(input string name);
    tests_run++;
    $display("test %0d %s finished, failed checks so far %0d", tests_run, name, err_cnt);
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin
    tile_addr_t first;
    tick        = 1'b0;
    game_over   = 1'b0;
    place       = 1'b0;
    place_addr  = '0;
    rd_addr     = '0;
    rd_exp      = '0;
    exp_addr    = '0;
    armed_ticks = 0;
    blast_ticks = 0;
    tick_div    = 0;
    cycle_cnt   = 0;
    err_cnt     = 0;
    tests_run   = 0;
    for (int i = 0; i < DEPTH; i++)
      model[i] = maze_start_tile(i);

    while (rst) @(posedge clk);
    sweep_map();
    report_test("reset state");

    first = interior_addr();
    drop_bomb(first, 1'b1);
    while (!explode_active) @(posedge clk);
    report_test("fuse");

    wait_blast_done();
    apply_cross(first);
    sweep_map();
    report_test("blast and clear");

    // Corner bomb has only the right and lower neighbours
    drop_bomb('0, 1'b1);
    wait_blast_done();
    apply_cross(0);
    sweep_map();
    report_test("corner bomb");

    first = interior_addr();
    drop_bomb(first, 1'b1);
    while (!bomb_armed) @(posedge clk);
    drop_bomb(interior_addr(), 1'b0);
    while (!explode_active) @(posedge clk);
    drop_bomb(interior_addr(), 1'b0);
    wait_blast_done();
    apply_cross(first);
    report_test("second place ignored");

    // Cancel once in the fuse and once in the blast and the map stays as it is
    drop_bomb(interior_addr(), 1'b1);
    while (!bomb_armed) @(posedge clk);
    pulse_game_over();
    drop_bomb(interior_addr(), 1'b1);
    while (!explode_active) @(posedge clk);
    repeat (3) @(posedge clk);
    pulse_game_over();
    sweep_map();
    report_test("game over");

    $display("%0d tests run, %0d checks failed", tests_run, err_cnt);
    if (err_cnt == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

//--- list.f
+incdir+.
bomber_pkg.sv
bomb_fuse.sv
explode_logic.sv
blast_clear.sv
tile_map.sv
bomber_blast_top.sv
tb_clock.sv
bomber_tb.sv

//--- Bender.yml
package:
  name: bomber_blast

export_include_dirs:
  - .

sources:
  - bomber_pkg.sv
  - bomb_fuse.sv
  - explode_logic.sv
  - blast_clear.sv
  - tile_map.sv
  - bomber_blast_top.sv
  - target: test
    files:
      - tb_clock.sv
      - bomber_tb.sv
